// File: Makefile
VERILATOR ?= verilator
TOP       ?= blitter_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/blit_vram_model.sv
/*
 * Video RAM model for the blitter testbench.
 * 64K words filled from the address, one access at a time, each acked after
 * a random delay of 0 to 3 cycles. Accepted writes are logged in order.
 */

`timescale 1ns/1ps

module blit_vram_model
    import blit_vram_pkg::*;
#(
    parameter int SEED = 50
) (
    input  logic      clk,
    input  logic      reset_i,
    input  vram_req_t req_i,
    output logic      ack_o,
    output word_t     data_o
);

    word_t mem [0:65535];
    addr_t wr_log [$];                      // addresses of acked writes

    initial begin
        int   delay;
        logic pending;
        delay   = 0;
        pending = 1'b0;
        ack_o  <= 1'b0;
        data_o <= '0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = word_t'(i * 40503 + 12345);    // distinct word per address
        end
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            ack_o <= 1'b0;
            if (reset_i) begin
                pending = 1'b0;
            end else if (pending) begin
                if (delay == 0) begin
                    ack_o  <= 1'b1;
                    data_o <= mem[req_i.addr];
                    if (req_i.wr) begin
                        for (int i = 0; i < 4; i++) begin
                            if (req_i.mask[i]) begin
                                mem[req_i.addr][4*i +: 4] = req_i.data[4*i +: 4];
                            end
                        end
                        wr_log.push_back(req_i.addr);
                    end
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end else if (req_i.sel && !ack_o) begin
                delay   = int'($urandom % 4);   // extra wait cycles
                pending = 1'b1;
            end
        end
    end

endmodule

// File: sim/blitter_tb.sv
/*
 * Testbench for the blitter top level.
 * Programs blits through the register port, predicts every VRAM write from
 * the blit rules and checks each write ack with concurrent assertions.
 * Covers reset state, copy, logic ops, shifts, transparency and queueing.
 */

`timescale 1ns/1ps

module blitter_tb
    import blit_vram_pkg::*, blit_reg_pkg::*;
();

    localparam int CLK_PERIOD        = 40;
    localparam int DRIVE_SKEW        = 2;
    localparam int CYCLES_PER_ACCESS = 20 * 4;

    typedef struct packed {
        addr_t        addr;
        word_t        data;
        nibble_mask_t mask;
    } exp_wr_t;

    logic      clk;
    logic      reset;
    logic      reg_wr;
    reg_num_t  reg_num;
    word_t     reg_data;
    logic      vram_ack;
    word_t     vram_data;
    vram_req_t vram;
    logic      busy;
    logic      full;
    logic      done;
    logic      wr_ack;

    exp_wr_t   exp_wr [0:511];
    exp_wr_t   exp_head;
    word_t     ref_mem [0:65535];
    word_t     prev_a = '0;                 // last A word read for the carry
    word_t     prev_b = '0;
    int        exp_cnt = 0;
    int        wr_idx = 0;
    int        done_cnt = 0;
    int        done_goal = 0;
    int        cycle = 0;
    int        deadline = 1000;
    int        budget = 0;                  // VRAM accesses of the current test
    int        err_cnt = 0;
    int        err_mark = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    logic      chain_watch = 1'b0;
    string     test_name = "reset";

    blitter_top #(
        .LINE_W      (15)
    ) i_blitter_top (
        .clk         (clk),
        .reset_i     (reset),
        .reg_wr_i    (reg_wr),
        .reg_num_i   (reg_num),
        .reg_data_i  (reg_data),
        .vram_ack_i  (vram_ack),
        .vram_data_i (vram_data),
        .vram_o      (vram),
        .busy_o      (busy),
        .full_o      (full),
        .done_o      (done)
    );

    blit_vram_model #(
        .SEED    (50)
    ) i_vram (
        .clk     (clk),
        .reset_i (reset),
        .req_i   (vram),
        .ack_o   (vram_ack),
        .data_o  (vram_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign wr_ack   = vram.sel && vram.wr && vram_ack;
    assign exp_head = exp_wr[wr_idx];

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (wr_ack) begin
            wr_idx <= wr_idx + 1;
        end
        if (done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic report_value(input string what, input logic [15:0] exp, input logic [15:0] act);
        err_cnt++;
        $display("error %s: %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    a_wr_known: assert property (@(posedge clk) disable iff (reset) wr_ack |-> wr_idx < exp_cnt)
        else report_failure($sformatf("write to %h that no blit should make", $sampled(vram.addr)));

    a_wr_addr: assert property (@(posedge clk) disable iff (reset)
        wr_ack |-> vram.addr == exp_head.addr)
        else report_value($sformatf("write %0d address", $sampled(wr_idx)),
                          $sampled(exp_head.addr), $sampled(vram.addr));

    a_wr_data: assert property (@(posedge clk) disable iff (reset)
        wr_ack |-> vram.data == exp_head.data)
        else report_value($sformatf("write %0d data", $sampled(wr_idx)),
                          $sampled(exp_head.data), $sampled(vram.data));

    a_wr_mask: assert property (@(posedge clk) disable iff (reset)
        wr_ack |-> vram.mask == exp_head.mask)
        else report_value($sformatf("write %0d mask", $sampled(wr_idx)),
                          16'($sampled(exp_head.mask)), 16'($sampled(vram.mask)));

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else report_failure("done stayed high for more than one cycle");

    a_busy_chained: assert property (@(posedge clk) disable iff (reset) chain_watch |-> busy)
        else report_failure("busy dropped between two queued blits");

    // ends the run when a test overruns its cycle budget
    initial begin
        while (cycle <= deadline) begin
            @(posedge clk);
        end
        $display("timeout in test %s: blit did not finish by cycle %0d", test_name, cycle);
        $display("Test failed");
        $finish;
    end

    // low nibbles of the previous word shift in on top of the next source word
    function automatic word_t shift_in(input word_t cur, input word_t prev, input shift_t n);
        logic [31:0] both;
        both = {prev, cur};
        return word_t'(both >> (4 * n));
    endfunction

    function automatic nibble_mask_t transparency(input word_t b, input logic [7:0] t);
        nibble_mask_t m;
        m = '1;
        for (int i = 0; i < 4; i++) begin
            if (b[4*i +: 4] == t[4*(i%2) +: 4]) begin
                m[i] = 1'b0;                // odd nibbles against t[7:4]
            end
        end
        return m;
    endfunction

    function automatic blit_regs_t base_cfg(input addr_t src_a, input addr_t src_b,
                                            input addr_t dst_d, input word_t lines,
                                            input word_t words);
        blit_regs_t c;
        c            = '0;
        c.first_mask = '1;
        c.last_mask  = '1;
        c.src_a      = src_a;
        c.src_b      = src_b;
        c.dst_d      = dst_d;
        c.lines      = lines;
        c.words      = words;
        return c;
    endfunction

    task automatic model_blit(input blit_regs_t c);
        addr_t        sa;
        addr_t        sb;
        addr_t        sd;
        word_t        a;
        word_t        b;
        word_t        d;
        nibble_mask_t m;
        sa = c.src_a;
        sb = c.src_b;
        sd = c.dst_d;
        a  = c.src_a;                       // constant operands
        b  = c.src_b;
        for (int l = 0; l <= int'(c.lines); l++) begin
            for (int w = 0; w <= int'(c.words); w++) begin
                if (!c.a_const) begin
                    a      = shift_in(ref_mem[sa], prev_a, c.shift_count);
                    prev_a = ref_mem[sa];
                end
                if (!c.b_const) begin
                    b      = shift_in(ref_mem[sb], prev_b, c.shift_count);
                    prev_b = ref_mem[sb];
                end
                d = (a & (c.b_not ? ~b : b)) ^ c.val_c;
                m = transparency(b, c.transp_t);
                if (w == 0) begin
                    m = m & c.first_mask;
                end
                if (w == int'(c.words)) begin
                    m = m & c.last_mask;
                end
                exp_wr[exp_cnt] = {sd, d, m};
                exp_cnt++;
                for (int i = 0; i < 4; i++) begin
                    if (m[i]) begin
                        ref_mem[sd][4*i +: 4] = d[4*i +: 4];
                    end
                end
                sa++;
                sb++;
                sd++;
            end
            sa += c.mod_a;
            sb += c.mod_b;
            sd += c.mod_d;
        end
        budget += (int'(c.lines) + 1) * (int'(c.words) + 1)
                  * (1 + int'(!c.a_const) + int'(!c.b_const));
    endtask

    // called at a drive point and returns at the next one
    task automatic write_reg(input reg_num_t num, input word_t data);
        reg_wr   = 1'b1;
        reg_num  = num;
        reg_data = data;
        @(posedge clk);
        #(DRIVE_SKEW);
        reg_wr   = 1'b0;
    endtask

    task automatic program_blit(input blit_regs_t c);
        model_blit(c);
        write_reg(REG_CTRL, {c.transp_t, 5'b0, c.b_not, c.b_const, c.a_const});
        write_reg(REG_SHIFT, {c.first_mask, c.last_mask, 6'b0, c.shift_count});
        write_reg(REG_MOD_A, c.mod_a);
        write_reg(REG_MOD_B, c.mod_b);
        write_reg(REG_MOD_D, c.mod_d);
        write_reg(REG_SRC_A, c.src_a);
        write_reg(REG_SRC_B, c.src_b);
        write_reg(REG_VAL_C, c.val_c);
        write_reg(REG_DST_D, c.dst_d);
        write_reg(REG_LINES, c.lines);
        write_reg(REG_WORDS, c.words);      // queues the blit
        done_goal++;
    endtask

    task automatic wait_done(input int target);
        deadline = cycle + CYCLES_PER_ACCESS * budget + 100;
        while (done_cnt < target) begin
            @(posedge clk);
            #(DRIVE_SKEW);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = err_cnt;
        budget    = 0;
        deadline  = cycle + 200;
    endtask

    task automatic end_test();
        wait_done(done_goal);
        assert (i_vram.wr_log.size() == exp_cnt)
            else report_value("write count", 16'(exp_cnt), 16'(i_vram.wr_log.size()));
        tests_run++;
        if (err_cnt != err_mark) begin
            tests_failed++;
            $display("test %s: FAIL", test_name);
        end else begin
            $display("test %s: pass, %0d writes so far", test_name, exp_cnt);
        end
    endtask

    initial begin
        blit_regs_t cfg;
        blit_regs_t cfg2;
        reset    = 1'b1;
        reg_wr   = 1'b0;
        reg_num  = '0;
        reg_data = '0;
        repeat (10) @(posedge clk);
        #(DRIVE_SKEW);
        reset = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = i_vram.mem[i];     // start from the preloaded pattern
        end

        begin_test("reset");
        assert (!busy && !full && !done && !vram.sel)
            else report_failure("status outputs not idle after reset");
        end_test();

        begin_test("copy");
        cfg         = base_cfg(16'h1000, 16'hFFFF, 16'h8000, 16'd2, 16'd4);
        cfg.b_const = 1'b1;
        cfg.mod_a   = 16'd3;
        cfg.mod_d   = 16'd11;
        program_blit(cfg);
        end_test();

        for (int inv = 0; inv < 2; inv++) begin
            begin_test($sformatf("logic_b_not_%0d", inv));
            cfg       = base_cfg(16'h2000, 16'h3000, 16'h9000 + 16'(inv * 256), 16'd3, 16'd5);
            cfg.b_not = inv[0];
            cfg.val_c = 16'h5A5A;
            cfg.mod_a = 16'd2;
            cfg.mod_b = 16'd5;
            cfg.mod_d = 16'd4;
            program_blit(cfg);
            end_test();
        end

        for (int n = 1; n < 4; n++) begin
            begin_test($sformatf("shift_%0d", n));
            cfg             = base_cfg(16'h4000, 16'h4800, 16'hA000 + 16'(n * 256), 16'd2, 16'd4);
            cfg.shift_count = shift_t'(n);
            cfg.first_mask  = nibble_mask_t'(4'hF >> n);
            cfg.last_mask   = nibble_mask_t'(4'hF << n);
            cfg.mod_a       = 16'd1;
            cfg.mod_b       = 16'd2;
            program_blit(cfg);
            end_test();
        end

        begin_test("transparency");
        cfg          = base_cfg(16'h5000, 16'h5800, 16'hD000, 16'd1, 16'd7);
        cfg.transp_t = ref_mem[16'h5802][7:0];  // matches two nibbles of one B word
        program_blit(cfg);
        end_test();

        begin_test("queue");
        cfg       = base_cfg(16'h6000, 16'h6800, 16'hB000, 16'd3, 16'd7);
        cfg.val_c = 16'hFF00;
        program_blit(cfg);
        assert (full) else report_failure("full not set after the word count write");
        while (full) begin
            @(posedge clk);
            #(DRIVE_SKEW);
        end
        cfg2             = base_cfg(16'hB000, 16'h0F0F, 16'hC000, 16'd2, 16'd3);
        cfg2.b_const     = 1'b1;
        cfg2.b_not       = 1'b1;
        cfg2.val_c       = 16'h1234;
        cfg2.shift_count = 2'd2;
        cfg2.mod_a       = 16'd4;           // reads back what the first blit wrote
        program_blit(cfg2);
        assert (full && busy)
            else report_failure("second blit did not raise full while the first one ran");
        chain_watch = 1'b1;
        wait_done(done_goal - 1);
        chain_watch = 1'b0;
        end_test();

        $display("tests run %0d, failing tests %0d, errors %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: source/blit_logic_unit.sv
/*
 * Operand registers and logic operation of the blitter.
 * A, B and C are loaded as constants at blit setup; A and B are then
 * replaced by shifted VRAM words as they arrive. Produces D and the
 * 4-bit transparency write mask computed from B.
 */

`timescale 1ns/1ps

module blit_logic_unit
    import blit_vram_pkg::*, blit_reg_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  blit_regs_t   regs_i,
    input  logic         load_consts_i,     // setup cycle of a blit
    input  logic         ld_a_i,
    input  logic         ld_b_i,
    input  word_t        shifted_i,
    output word_t        result_o,
    output nibble_mask_t transp_mask_o
);

    word_t      a_q;
    word_t      b_q;
    word_t      c_q;
    word_t      b_eff;
    logic       b_not_q;
    logic [7:0] transp_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            b_not_q  <= 1'b0;
            transp_q <= '0;
        end else if (load_consts_i) begin
            b_not_q  <= regs_i.b_not;
            transp_q <= regs_i.transp_t;
        end
    end

    always_ff @(posedge clk) begin
        if (load_consts_i) begin
            a_q <= regs_i.src_a;            // constant unless A gets read
            b_q <= regs_i.src_b;
            c_q <= regs_i.val_c;
        end
        if (ld_a_i) begin
            a_q <= shifted_i;
        end
        if (ld_b_i) begin
            b_q <= shifted_i;
        end
    end

    assign b_eff    = b_not_q ? ~b_q : b_q;
    assign result_o = (a_q & b_eff) ^ c_q;

    // odd nibbles compare with T[7:4], even ones with T[3:0]
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            transp_mask_o[i] = (b_q[4*i +: 4] != (i[0] ? transp_q[7:4] : transp_q[3:0]));
        end
    end

endmodule

// File: source/blit_reg_pkg.sv
/*
 * Register map and settings layout of the blitter.
 * Holds the register indices, bit positions inside CTRL and SHIFT, and the
 * struct that carries one queued blit from the register bank to the engine.
 */

package blit_reg_pkg;

    import blit_vram_pkg::*;

    typedef logic [3:0] reg_num_t;

    localparam reg_num_t REG_CTRL  = 4'd0;
    localparam reg_num_t REG_SHIFT = 4'd1;
    localparam reg_num_t REG_MOD_A = 4'd2;
    localparam reg_num_t REG_MOD_B = 4'd3;
    localparam reg_num_t REG_MOD_D = 4'd5;  // index 4 is not decoded
    localparam reg_num_t REG_SRC_A = 4'd6;
    localparam reg_num_t REG_SRC_B = 4'd7;
    localparam reg_num_t REG_VAL_C = 4'd8;
    localparam reg_num_t REG_DST_D = 4'd9;
    localparam reg_num_t REG_LINES = 4'd10;
    localparam reg_num_t REG_WORDS = 4'd11; // writing this one queues the blit

    // CTRL layout
    localparam int CTRL_A_CONST_BIT = 0;
    localparam int CTRL_B_CONST_BIT = 1;
    localparam int CTRL_B_NOT_BIT   = 2;
    localparam int CTRL_T_LSB       = 8;    // transparency value in 15:8

    // SHIFT layout
    localparam int SHIFT_COUNT_LSB  = 0;
    localparam int SHIFT_LAST_LSB   = 8;
    localparam int SHIFT_FIRST_LSB  = 12;

    typedef struct packed {
        logic         a_const;
        logic         b_const;
        logic         b_not;
        logic [7:0]   transp_t;
        shift_t       shift_count;
        nibble_mask_t first_mask;
        nibble_mask_t last_mask;
        word_t        mod_a;
        word_t        mod_b;
        word_t        mod_d;
        addr_t        src_a;                // also constant A value
        addr_t        src_b;                // also constant B value
        word_t        val_c;
        addr_t        dst_d;
        word_t        lines;                // line count minus one
        word_t        words;                // word count minus one
    } blit_regs_t;

endpackage

// File: source/blit_reg_queue.sv
/*
 * Blitter register bank with a single-entry queue.
 * Register writes land here immediately; writing the word count marks the
 * settings as queued until the sequencer takes them in its SETUP cycle.
 */

`timescale 1ns/1ps

module blit_reg_queue
    import blit_vram_pkg::*, blit_reg_pkg::*;
#(
    parameter int LINE_W = 15               // width of the line count
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       reg_wr_i,            // write strobe, no wait
    input  reg_num_t   reg_num_i,
    input  word_t      reg_data_i,
    input  logic       take_i,              // sequencer copies regs_o now
    output blit_regs_t regs_o,
    output logic       queued_o
);

    localparam word_t LINE_MASK = word_t'((32'd1 << LINE_W) - 32'd1);

    blit_regs_t regs_q;
    logic       queued_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_q   <= '0;
            queued_q <= 1'b0;
        end else begin
            if (take_i) begin
                queued_q <= 1'b0;           // settings now owned by the sequencer
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    REG_CTRL: begin
                        regs_q.transp_t <= reg_data_i[CTRL_T_LSB +: 8];
                        regs_q.b_not    <= reg_data_i[CTRL_B_NOT_BIT];
                        regs_q.b_const  <= reg_data_i[CTRL_B_CONST_BIT];
                        regs_q.a_const  <= reg_data_i[CTRL_A_CONST_BIT];
                    end
                    REG_SHIFT: begin
                        regs_q.first_mask  <= reg_data_i[SHIFT_FIRST_LSB +: 4];
                        regs_q.last_mask   <= reg_data_i[SHIFT_LAST_LSB +: 4];
                        regs_q.shift_count <= reg_data_i[SHIFT_COUNT_LSB +: 2];
                    end
                    REG_MOD_A: regs_q.mod_a <= reg_data_i;
                    REG_MOD_B: regs_q.mod_b <= reg_data_i;
                    REG_MOD_D: regs_q.mod_d <= reg_data_i;
                    REG_SRC_A: regs_q.src_a <= reg_data_i;
                    REG_SRC_B: regs_q.src_b <= reg_data_i;
                    REG_VAL_C: regs_q.val_c <= reg_data_i;
                    REG_DST_D: regs_q.dst_d <= reg_data_i;
                    REG_LINES: regs_q.lines <= reg_data_i & LINE_MASK;
                    REG_WORDS: begin
                        regs_q.words <= reg_data_i;
                        queued_q     <= 1'b1;   // wins over a take in the same cycle
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign regs_o   = regs_q;
    assign queued_o = queued_q;

    // the sequencer only takes settings that were actually queued
    a_take_when_queued: assert property (
        @(posedge clk) disable iff (reset_i) take_i |-> queued_o
    ) else $error("blit_reg_queue: take without a queued blit");

endmodule

// File: source/blit_sequencer.sv
/*
 * Blit sequencer FSM.
 * Copies the queued settings, then walks the rectangle line by line:
 * optional reads of A and B, one write of D per word, modulo add at the
 * end of each line. One VRAM access is outstanding at a time.
 */

`timescale 1ns/1ps

module blit_sequencer
    import blit_vram_pkg::*, blit_reg_pkg::*;
#(
    parameter int LINE_W = 15
) (
    input  logic         clk,
    input  logic         reset_i,
    input  blit_regs_t   regs_i,
    input  logic         queued_i,
    input  logic         vram_ack_i,
    input  word_t        result_i,
    input  nibble_mask_t transp_mask_i,
    output logic         take_o,            // copy regs_i this cycle
    output logic         load_consts_o,
    output logic         ld_a_o,
    output logic         ld_b_o,
    output logic         rd_ack_o,
    output logic         src_b_o,
    output shift_t       shift_cnt_o,       // shift count of the running blit
    output vram_req_t    vram_o,
    output logic         busy_o,
    output logic         done_o
);

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        LINE_BEG,
        RD_A,
        RD_B,
        WR_D,
        LINE_END
    } blit_state_t;

    blit_state_t  state;
    blit_state_t  first_acc;                // first access of each word

    logic         a_const;
    logic         b_const;
    logic         done_q;
    logic [LINE_W:0] line_cnt;              // top bit flags the last line
    logic [16:0]  word_cnt;                 // top bit flags the last word
    nibble_mask_t first_word_mask;

    shift_t       shift_cnt;
    nibble_mask_t first_mask;
    nibble_mask_t last_mask;
    word_t        mod_a;
    word_t        mod_b;
    word_t        mod_d;
    word_t        words;
    addr_t        src_a;
    addr_t        src_b;
    addr_t        dst_d;

    logic         last_word;
    logic         last_line;
    nibble_mask_t wr_mask;

    assign last_word = word_cnt[16];
    assign last_line = line_cnt[LINE_W];
    assign first_acc = !a_const ? RD_A : (!b_const ? RD_B : WR_D);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state           <= IDLE;
            done_q          <= 1'b0;
            a_const         <= 1'b0;
            b_const         <= 1'b0;
            line_cnt        <= '0;
            word_cnt        <= '0;
            first_word_mask <= '1;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (queued_i) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    a_const  <= regs_i.a_const;
                    b_const  <= regs_i.b_const;
                    line_cnt <= {1'b0, regs_i.lines[LINE_W-1:0]};
                    state    <= LINE_BEG;
                end
                LINE_BEG: begin
                    first_word_mask <= first_mask;
                    line_cnt        <= line_cnt - 1'b1;           // pre-decrement
                    word_cnt        <= {1'b0, words} - 17'd1;     // pre-decrement
                    state           <= first_acc;
                end
                RD_A: begin
                    if (vram_ack_i) begin
                        state <= b_const ? WR_D : RD_B;
                    end
                end
                RD_B: begin
                    if (vram_ack_i) begin
                        state <= WR_D;
                    end
                end
                WR_D: begin
                    if (vram_ack_i) begin
                        word_cnt        <= word_cnt - 1'b1;
                        first_word_mask <= '1;
                        state           <= last_word ? LINE_END : first_acc;
                    end
                end
                LINE_END: begin
                    if (last_line) begin
                        done_q <= 1'b1;
                        state  <= queued_i ? SETUP : IDLE;    // back to back blits
                    end else begin
                        state  <= LINE_BEG;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // working copy of addresses and line settings
    always_ff @(posedge clk) begin
        if (state == SETUP) begin
            shift_cnt  <= regs_i.shift_count;
            first_mask <= regs_i.first_mask;
            last_mask  <= regs_i.last_mask;
            mod_a      <= regs_i.mod_a;
            mod_b      <= regs_i.mod_b;
            mod_d      <= regs_i.mod_d;
            words      <= regs_i.words;
            src_a      <= regs_i.src_a;
            src_b      <= regs_i.src_b;
            dst_d      <= regs_i.dst_d;
        end else if (state == WR_D && vram_ack_i) begin
            src_a <= src_a + 1'b1;
            src_b <= src_b + 1'b1;
            dst_d <= dst_d + 1'b1;
        end else if (state == LINE_END) begin
            src_a <= src_a + mod_a;
            src_b <= src_b + mod_b;
            dst_d <= dst_d + mod_d;
        end
    end

    assign wr_mask = first_word_mask & (last_word ? last_mask : '1) & transp_mask_i;

    // request fields come from registers only, so they hold until ack
    always_comb begin
        vram_o.sel  = (state == RD_A) || (state == RD_B) || (state == WR_D);
        vram_o.wr   = (state == WR_D);
        vram_o.addr = (state == RD_A) ? src_a : ((state == RD_B) ? src_b : dst_d);
        vram_o.data = result_i;
        vram_o.mask = wr_mask;
    end

    assign take_o        = (state == SETUP);
    assign load_consts_o = (state == SETUP);
    assign ld_a_o        = (state == RD_A) && vram_ack_i;
    assign ld_b_o        = (state == RD_B) && vram_ack_i;
    assign rd_ack_o      = ld_a_o || ld_b_o;
    assign src_b_o       = (state == RD_B);
    assign shift_cnt_o   = shift_cnt;
    assign busy_o        = (state != IDLE);
    assign done_o        = done_q;

    a_req_stable: assert property (
        @(posedge clk) disable iff (reset_i)
        vram_o.sel && !vram_ack_i |=> $stable(vram_o)
    ) else $error("blit_sequencer: VRAM request changed before ack");

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset_i)
        state inside {IDLE, SETUP, LINE_BEG, RD_A, RD_B, WR_D, LINE_END}
    ) else $error("blit_sequencer: illegal state");

endmodule

// File: source/blit_shifter.sv
/*
 * Nibble right shifter for source words read from VRAM.
 * Keeps the previous word of A and of B so the nibbles shifted out of one
 * word carry into the next word of the same source, across lines and blits.
 */

`timescale 1ns/1ps

module blit_shifter
    import blit_vram_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  shift_t shift_i,                 // 0 to 3 nibbles
    input  logic   src_b_i,                 // word being read belongs to B
    input  logic   rd_ack_i,                // read data valid this cycle
    input  word_t  data_i,
    output word_t  shift_o
);

    word_t last_a;
    word_t last_b;
    word_t prev;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_a <= '0;
            last_b <= '0;
        end else if (rd_ack_i) begin
            if (src_b_i) begin
                last_b <= data_i;
            end else begin
                last_a <= data_i;
            end
        end
    end

    assign prev = src_b_i ? last_b : last_a;

    // low nibbles of the previous word fill the top of the result
    always_comb begin
        case (shift_i)
            2'd0:    shift_o = data_i;
            2'd1:    shift_o = {prev[3:0], data_i[15:4]};
            2'd2:    shift_o = {prev[7:0], data_i[15:8]};
            default: shift_o = {prev[11:0], data_i[15:12]};
        endcase
    end

endmodule

// File: source/blit_vram_pkg.sv
/*
 * VRAM bus types shared by the blitter units.
 * Word, address and nibble mask widths, plus the request struct that the
 * sequencer drives toward video RAM. Import with blit_vram_pkg::*.
 */

package blit_vram_pkg;

    typedef logic [15:0] word_t;            // one VRAM data word
    typedef logic [15:0] addr_t;            // VRAM word address
    typedef logic [3:0]  nibble_mask_t;     // bit i enables nibble i
    typedef logic [1:0]  shift_t;           // right shift in nibbles

    // request toward VRAM that is held until ack
    typedef struct packed {
        logic         sel;                  // access requested
        logic         wr;                   // 1 = write, 0 = read
        addr_t        addr;
        word_t        data;                 // write data
        nibble_mask_t mask;                 // write nibble enables
    } vram_req_t;

endpackage

// File: source/blitter_top.sv
/*
 * Top level of the 2D bit-blit engine.
 * Connects the register queue, sequencer, shifter and logic unit.
 * Software writes registers through reg_wr_i; the engine masters VRAM.
 */

`timescale 1ns/1ps

module blitter_top
    import blit_vram_pkg::*, blit_reg_pkg::*;
#(
    parameter int LINE_W = 15
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      reg_wr_i,
    input  reg_num_t  reg_num_i,
    input  word_t     reg_data_i,
    input  logic      vram_ack_i,
    input  word_t     vram_data_i,
    output vram_req_t vram_o,
    output logic      busy_o,
    output logic      full_o,
    output logic      done_o
);

    blit_regs_t   regs;
    logic         queued;
    logic         take;
    logic         load_consts;
    logic         ld_a;
    logic         ld_b;
    logic         rd_ack;
    logic         src_b;
    shift_t       shift_cnt;
    word_t        shifted;
    word_t        result;
    nibble_mask_t transp_mask;

    assign full_o = queued;

    blit_reg_queue #(
        .LINE_W     (LINE_W)
    ) i_blit_reg_queue (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .take_i     (take),
        .regs_o     (regs),
        .queued_o   (queued)
    );

    blit_sequencer #(
        .LINE_W         (LINE_W)
    ) i_blit_sequencer (
        .clk            (clk),
        .reset_i        (reset_i),
        .regs_i         (regs),
        .queued_i       (queued),
        .vram_ack_i     (vram_ack_i),
        .result_i       (result),
        .transp_mask_i  (transp_mask),
        .take_o         (take),
        .load_consts_o  (load_consts),
        .ld_a_o         (ld_a),
        .ld_b_o         (ld_b),
        .rd_ack_o       (rd_ack),
        .src_b_o        (src_b),
        .shift_cnt_o    (shift_cnt),
        .vram_o         (vram_o),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    blit_shifter i_blit_shifter (
        .clk        (clk),
        .reset_i    (reset_i),
        .shift_i    (shift_cnt),
        .src_b_i    (src_b),
        .rd_ack_i   (rd_ack),
        .data_i     (vram_data_i),
        .shift_o    (shifted)
    );

    blit_logic_unit i_blit_logic_unit (
        .clk            (clk),
        .reset_i        (reset_i),
        .regs_i         (regs),
        .load_consts_i  (load_consts),
        .ld_a_i         (ld_a),
        .ld_b_i         (ld_b),
        .shifted_i      (shifted),
        .result_o       (result),
        .transp_mask_o  (transp_mask)
    );

endmodule

// File: sources.f
source/blit_vram_pkg.sv
source/blit_reg_pkg.sv
source/blit_reg_queue.sv
source/blit_shifter.sv
source/blit_logic_unit.sv
source/blit_sequencer.sv
source/blitter_top.sv
sim/blit_vram_model.sv
sim/blitter_tb.sv
